//--- logic/riscv_controller.sv
////////////////////////////////////////////////////////////
// controller
// sequences fetch, execute and memory, decodes the subset
////////////////////////////////////////////////////////////

module riscv_controller (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  riscv_core_pkg::word_t   instr_i,
  output logic                    fetch_req_o,
  output logic                    pc_advance_o,
  output logic                    rf_we_o,
  output logic                    wb_sel_csr_o,
  output logic                    use_imm_o,
  output logic                    retire_o,
  output logic                    core_busy_o,
  output riscv_core_pkg::csr_op_e csr_op_o,
  riscv_lsu_if.ctrl               lsu
);
  import riscv_core_pkg::*;
  import riscv_isa_pkg::*;

  ctrl_state_e state_q, state_d;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        legal;     // one of the supported encodings
  logic        is_mem;    // LW or SW
  logic        is_store;
  logic        is_csr;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  ////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////
  always_comb begin
    legal    = 1'b0;
    is_mem   = 1'b0;
    is_store = 1'b0;
    is_csr   = 1'b0;
    case (opcode)
      OPC_OP:     legal = (funct3 == F3_ADD) && (instr_i[31:25] == '0);  // add only
      OPC_OP_IMM: legal = (funct3 == F3_ADD);
      OPC_LOAD: begin
        legal  = (funct3 == F3_LW);
        is_mem = 1'b1;
      end
      OPC_STORE: begin
        legal    = (funct3 == F3_SW);
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      OPC_SYSTEM: begin
        legal  = (funct3 == F3_CSRRW) || (funct3 == F3_CSRRS);
        is_csr = 1'b1;
      end
      default: legal = 1'b0;  // all zero word lands here
    endcase
  end

  assign use_imm_o    = (opcode != OPC_OP);  // addi, lw, sw
  assign wb_sel_csr_o = is_csr;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d     = state_q;
    fetch_req_o = 1'b0;
    retire_o    = 1'b0;
    rf_we_o     = 1'b0;
    lsu.req     = 1'b0;
    csr_op_o    = CSR_OP_NONE;
    case (state_q)
      IDLE:       if (fetch_enable_i) state_d = FETCH;  // only sampled here
      FETCH: begin
        fetch_req_o = 1'b1;
        state_d     = WAIT_INSTR;
      end
      WAIT_INSTR: if (instr_valid_i) state_d = EXECUTE;
      EXECUTE: begin
        if (!legal) begin
          state_d = HALT;
        end else if (is_mem) begin
          lsu.req = 1'b1;           // lsu holds it until grant
          state_d = MEM_WAIT;
        end else begin
          retire_o = 1'b1;
          rf_we_o  = 1'b1;          // add, addi, csr read
          if (is_csr) csr_op_o = (funct3 == F3_CSRRW) ? CSR_OP_WRITE : CSR_OP_SET;
          state_d  = FETCH;
        end
      end
      MEM_WAIT: begin
        if (lsu.done) begin
          retire_o = 1'b1;
          rf_we_o  = !is_store;     // load writeback with rvalid
          state_d  = FETCH;
        end
      end
      default: state_d = HALT;      // stuck until reset
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign lsu.we       = is_store;
  assign pc_advance_o = retire_o;  // no branches so pc steps on every retire
  assign core_busy_o  = (state_q != IDLE) && (state_q != HALT);

  // lsu completion only while the FSM waits for it
  a_done_in_mem_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    lsu.done |-> state_q == MEM_WAIT);

endmodule

//--- logic/riscv_core.sv
////////////////////////////////////////////////////////////
// riscv core top level
// non-pipelined RV32 subset core with instr and data buses
////////////////////////////////////////////////////////////

module riscv_core (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   fetch_enable_i,
  input  riscv_core_pkg::word_t                  boot_addr_i,
  // instruction bus
  output logic                                   instr_req_o,
  input  logic                                   instr_gnt_i,
  input  logic                                   instr_rvalid_i,
  output riscv_core_pkg::word_t                  instr_addr_o,
  input  riscv_core_pkg::word_t                  instr_rdata_i,
  // data bus
  output logic                                   data_req_o,
  input  logic                                   data_gnt_i,
  input  logic                                   data_rvalid_i,
  output logic                                   data_we_o,
  output logic [riscv_core_pkg::WORD_BYTES-1:0]  data_be_o,
  output riscv_core_pkg::word_t                  data_addr_o,
  output riscv_core_pkg::word_t                  data_wdata_o,
  input  riscv_core_pkg::word_t                  data_rdata_i,
  output logic                                   core_busy_o
);
  import riscv_core_pkg::*;

  logic      fetch_req;   // controller -> fetch
  logic      pc_advance;
  logic      instr_valid; // fetch -> controller
  word_t     instr;       // captured instruction word
  logic      rf_we;
  logic      wb_sel_csr;
  logic      use_imm;
  logic      retire;      // one pulse per instruction
  csr_op_e   csr_op;
  csr_addr_t csr_addr;
  word_t     csr_wdata;
  word_t     csr_rdata;

  riscv_lsu_if lsu_bus ();

  riscv_controller controller_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .fetch_req_o    (fetch_req),
    .pc_advance_o   (pc_advance),
    .rf_we_o        (rf_we),
    .wb_sel_csr_o   (wb_sel_csr),
    .use_imm_o      (use_imm),
    .retire_o       (retire),
    .core_busy_o    (core_busy_o),
    .csr_op_o       (csr_op),
    .lsu            (lsu_bus.ctrl)
  );

  riscv_fetch_unit fetch_unit_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_req_i    (fetch_req),
    .pc_advance_i   (pc_advance),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .boot_addr_i    (boot_addr_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_valid_o  (instr_valid),
    .instr_addr_o   (instr_addr_o),
    .instr_o        (instr)
  );

  riscv_ex_stage ex_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rf_we_i      (rf_we),
    .wb_sel_csr_i (wb_sel_csr),
    .use_imm_i    (use_imm),
    .instr_i      (instr),
    .csr_rdata_i  (csr_rdata),
    .csr_addr_o   (csr_addr),
    .csr_wdata_o  (csr_wdata),
    .lsu          (lsu_bus.ex)
  );

  riscv_load_store_unit load_store_unit_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .lsu           (lsu_bus.lsu)
  );

  // memory counters watch the bus itself
  riscv_cs_registers cs_registers_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .retire_i    (retire),
    .data_req_i  (data_req_o),
    .data_gnt_i  (data_gnt_i),
    .data_we_i   (data_we_o),
    .csr_op_i    (csr_op),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata)
  );

endmodule

//--- logic/riscv_core_pkg.sv
////////////////////////////////////////////////////////////
// riscv core package
// datapath widths, vector types and the FSM and CSR enums
////////////////////////////////////////////////////////////

package riscv_core_pkg;

  localparam int WORD_BYTES = 4;   // bytes per word, also pc step
  localparam int NUM_REGS   = 32;  // x0 .. x31

  typedef logic [8*WORD_BYTES-1:0] word_t;  // data or address word
  typedef logic [4:0]              reg_addr_t;
  typedef logic [11:0]             csr_addr_t;

  // one instruction in flight, so one state per phase
  typedef enum logic [2:0] {
    IDLE,        // waiting for fetch enable
    FETCH,       // launch instruction request
    WAIT_INSTR,  // grant and rvalid outstanding
    EXECUTE,     // decode, alu, csr, launch lsu
    MEM_WAIT,    // data access in flight
    HALT         // illegal instruction seen
  } ctrl_state_e;

  typedef enum logic [1:0] {
    CSR_OP_NONE,
    CSR_OP_WRITE,
    CSR_OP_SET
  } csr_op_e;

endpackage

//--- logic/riscv_cs_registers.sv
////////////////////////////////////////////////////////////
// control and status registers
// mscratch plus retired, load and store counters
////////////////////////////////////////////////////////////

module riscv_cs_registers (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      retire_i,
  input  logic                      data_req_i,
  input  logic                      data_gnt_i,
  input  logic                      data_we_i,
  input  riscv_core_pkg::csr_op_e   csr_op_i,
  input  riscv_core_pkg::csr_addr_t csr_addr_i,
  input  riscv_core_pkg::word_t     csr_wdata_i,
  output riscv_core_pkg::word_t     csr_rdata_o
);
  import riscv_core_pkg::*;
  import riscv_isa_pkg::*;

  word_t mscratch_q;
  word_t minstret_q;
  word_t load_cnt_q;
  word_t store_cnt_q;
  logic  mem_acc;     // request accepted this cycle

  assign mem_acc = data_req_i & data_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mscratch_q  <= '0;
      minstret_q  <= '0;
      load_cnt_q  <= '0;
      store_cnt_q <= '0;
    end else begin
      if (csr_addr_i == CSR_MSCRATCH) begin
        case (csr_op_i)
          CSR_OP_WRITE: mscratch_q <= csr_wdata_i;
          CSR_OP_SET:   mscratch_q <= mscratch_q | csr_wdata_i;
          default:      mscratch_q <= mscratch_q;
        endcase
      end
      if (retire_i)             minstret_q  <= minstret_q + 1'b1;
      if (mem_acc && !data_we_i) load_cnt_q  <= load_cnt_q + 1'b1;
      if (mem_acc && data_we_i)  store_cnt_q <= store_cnt_q + 1'b1;
    end
  end

  // reads see the value before this instruction's update
  always_comb begin
    case (csr_addr_i)
      CSR_MSCRATCH:  csr_rdata_o = mscratch_q;
      CSR_MINSTRET:  csr_rdata_o = minstret_q;
      CSR_LOAD_CNT:  csr_rdata_o = load_cnt_q;
      CSR_STORE_CNT: csr_rdata_o = store_cnt_q;
      default:       csr_rdata_o = '0;  // unmapped
    endcase
  end

endmodule

//--- logic/riscv_ex_stage.sv
////////////////////////////////////////////////////////////
// execute stage
// register file, immediates, adder and writeback select
////////////////////////////////////////////////////////////

module riscv_ex_stage (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      rf_we_i,
  input  logic                      wb_sel_csr_i,
  input  logic                      use_imm_i,
  input  riscv_core_pkg::word_t     instr_i,
  input  riscv_core_pkg::word_t     csr_rdata_i,
  output riscv_core_pkg::csr_addr_t csr_addr_o,
  output riscv_core_pkg::word_t     csr_wdata_o,
  riscv_lsu_if.ex                   lsu
);
  import riscv_core_pkg::*;
  import riscv_isa_pkg::*;

  word_t     rf_q [NUM_REGS];
  reg_addr_t rs1, rs2, rd;
  word_t     rs1_val, rs2_val;
  word_t     imm_i, imm_s;
  word_t     sum;         // alu result and memory address
  word_t     wb_data;
  logic      is_load;

  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];
  assign rd  = instr_i[11:7];

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  ////////////////////////////////////////////////////////////
  // immediates and adder
  ////////////////////////////////////////////////////////////
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};  // store split

  assign sum = rs1_val + (use_imm_i ? ((instr_i[6:0] == OPC_STORE) ? imm_s : imm_i)
                                    : rs2_val);

  assign lsu.addr  = sum;
  assign lsu.wdata = rs2_val;  // store data

  assign csr_addr_o  = instr_i[31:20];
  assign csr_wdata_o = rs1_val;

  ////////////////////////////////////////////////////////////
  // writeback
  ////////////////////////////////////////////////////////////
  assign is_load = (instr_i[6:0] == OPC_LOAD);
  assign wb_data = wb_sel_csr_i ? csr_rdata_i :
                   is_load      ? lsu.rdata   : sum;

  // rf_we_i for a load comes with lsu done
  always_ff @(posedge clk_i) begin
    if (!reset_i && rf_we_i && (rd != '0)) begin
      rf_q[rd] <= wb_data;  // x0 never written
    end
  end

endmodule

//--- logic/riscv_fetch_unit.sv
////////////////////////////////////////////////////////////
// fetch unit
// program counter and instruction bus master
////////////////////////////////////////////////////////////

module riscv_fetch_unit (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  fetch_req_i,
  input  logic                  pc_advance_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  riscv_core_pkg::word_t boot_addr_i,
  input  riscv_core_pkg::word_t instr_rdata_i,
  output logic                  instr_req_o,
  output logic                  instr_valid_o,
  output riscv_core_pkg::word_t instr_addr_o,
  output riscv_core_pkg::word_t instr_o
);
  import riscv_core_pkg::*;

  logic  req_q;    // request waiting for grant
  logic  wait_q;   // granted, rvalid pending
  word_t pc_q;
  word_t instr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      pc_q   <= boot_addr_i;  // first fetch goes here
    end else begin
      if (req_q && instr_gnt_i) begin
        req_q <= 1'b0;
      end else if (fetch_req_i) begin
        req_q <= 1'b1;
      end
      if (req_q && instr_gnt_i) begin
        wait_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        wait_q <= 1'b0;
      end
      if (pc_advance_i) pc_q <= pc_q + word_t'(WORD_BYTES);
    end
  end

  // instruction word, no reset
  always_ff @(posedge clk_i) begin
    if (wait_q && instr_rvalid_i) instr_q <= instr_rdata_i;
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = wait_q & instr_rvalid_i;  // execute starts next cycle
  assign instr_o       = instr_q;

  a_instr_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

//--- logic/riscv_isa_pkg.sv
////////////////////////////////////////////////////////////
// riscv isa package
// opcode, funct3 and CSR address encodings of the subset
////////////////////////////////////////////////////////////

package riscv_isa_pkg;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_LW    = 3'b010;  // word only
  localparam logic [2:0] F3_SW    = 3'b010;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // CSR map
  localparam riscv_core_pkg::csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam riscv_core_pkg::csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam riscv_core_pkg::csr_addr_t CSR_LOAD_CNT  = 12'h7C0;  // custom
  localparam riscv_core_pkg::csr_addr_t CSR_STORE_CNT = 12'h7C1;  // custom

endpackage

//--- logic/riscv_load_store_unit.sv
////////////////////////////////////////////////////////////
// load-store unit
// data bus master for word loads and stores
////////////////////////////////////////////////////////////

module riscv_load_store_unit (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  data_gnt_i,
  input  logic                                  data_rvalid_i,
  input  riscv_core_pkg::word_t                 data_rdata_i,
  output logic                                  data_req_o,
  output logic                                  data_we_o,
  output logic [riscv_core_pkg::WORD_BYTES-1:0] data_be_o,
  output riscv_core_pkg::word_t                 data_addr_o,
  output riscv_core_pkg::word_t                 data_wdata_o,
  riscv_lsu_if.lsu                              lsu
);
  import riscv_core_pkg::*;

  logic  req_q;    // waiting for grant
  logic  pend_q;   // granted, waiting for rvalid
  logic  we_q;
  word_t addr_q;
  word_t wdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      pend_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      if (lsu.req) begin
        req_q <= 1'b1;
        we_q  <= lsu.we;
      end else if (req_q && data_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && data_gnt_i) begin
        pend_q <= 1'b1;
      end else if (data_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  // payload, held until grant
  always_ff @(posedge clk_i) begin
    if (lsu.req) begin
      addr_q  <= lsu.addr;
      wdata_q <= lsu.wdata;
    end
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_be_o    = '1;  // word access only
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu.rdata = data_rdata_i;
  assign lsu.done  = pend_q & data_rvalid_i;

  a_data_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
                                  && $stable(data_we_o) && $stable(data_wdata_o));

endmodule

//--- logic/riscv_lsu_if.sv
////////////////////////////////////////////////////////////
// load-store interface
// controller and execute stage towards the LSU
////////////////////////////////////////////////////////////

interface riscv_lsu_if;
  import riscv_core_pkg::*;

  logic  req;    // single cycle launch from controller
  logic  we;     // store when high
  word_t addr;   // rs1 + imm from execute
  word_t wdata;  // rs2 from execute
  word_t rdata;  // load data, valid with done
  logic  done;   // single cycle, access completed

  modport ctrl (output req, output we, input done);
  modport ex   (output addr, output wdata, input rdata);
  modport lsu  (input req, input we, input addr, input wdata, output rdata, output done);

endinterface

//--- run.sh
#!/usr/bin/env bash
# verilator build and run of the core testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_riscv_core -f tb.f -o tb_riscv_core_sim

./obj_dir/tb_riscv_core_sim | tee sim.log

# the log decides the result
grep -q "^PASS: all tests$" sim.log

//--- sim/tb_riscv_core.sv
////////////////////////////////////////////////////////////
// riscv core testbench
// random latency memories, reference model, bus assertions
////////////////////////////////////////////////////////////

module tb_riscv_core;
  import riscv_core_pkg::*;
  import riscv_isa_pkg::*;

  localparam word_t BOOT_ADDR  = 32'h0000_0100;
  localparam int    MEM_WORDS  = 64;
  localparam int    WAIT_LIMIT = 400;  // cycles per wait

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic                  fetch_enable_i;
  word_t                 boot_addr_i;
  logic                  instr_req_o;
  logic                  instr_gnt_i    = 1'b0;
  logic                  instr_rvalid_i = 1'b0;
  word_t                 instr_addr_o;
  word_t                 instr_rdata_i  = '0;
  logic                  data_req_o;
  logic                  data_gnt_i     = 1'b0;
  logic                  data_rvalid_i  = 1'b0;
  logic                  data_we_o;
  logic [WORD_BYTES-1:0] data_be_o;
  word_t                 data_addr_o;
  word_t                 data_wdata_o;
  word_t                 data_rdata_i   = '0;
  logic                  core_busy_o;

  word_t imem [MEM_WORDS];   // program ending in a zero word
  word_t dmem [MEM_WORDS];   // seen by the data bus
  word_t m_mem [MEM_WORDS];  // model copy
  word_t m_rf [NUM_REGS];
  word_t m_mscratch, m_instret, m_loads, m_stores;

  // model results the assertions compare against
  word_t exp_pc    = BOOT_ADDR;
  word_t exp_addr  = '0;
  word_t exp_wdata = '0;
  logic  exp_we    = 1'b0;
  int    exp_count = 0;     // data accesses the model asked for
  logic  m_halted  = 1'b0;
  int    grants    = 0;     // data grants given
  int    accesses_done = 0; // data rvalids given

  int unsigned i_seed = 18459;
  int unsigned d_seed = 18459;
  int unsigned i_delay, d_delay;
  logic        i_pend, d_pend;
  word_t       i_off, i_word, d_rdata;

  string test_name = "";
  int    errors, tests_run, tests_failed, test_start_errors;
  logic  timed_out = 1'b0;

  always #10 clk_i = ~clk_i;

  riscv_core dut_i (.*);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int unsigned latency(int unsigned s);
    return (s >> 16) % 4;  // 0 to 3 cycles
  endfunction

  function automatic word_t fill_word(word_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic word_t encode_i(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t encode_r(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {7'b0, rs2, rs1, F3_ADD, rd, OPC_OP};  // add
  endfunction

  function automatic word_t encode_s(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
  endfunction

  task automatic report_mismatch(string what, word_t expected, word_t actual);
    errors++;
    $display("CHECK FAILED %s, %s: expected %h actual %h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model run on each delivered instruction
  ////////////////////////////////////////////////////////////
  function automatic word_t csr_value(csr_addr_t csr);
    case (csr)
      CSR_MSCRATCH:  return m_mscratch;
      CSR_MINSTRET:  return m_instret;
      CSR_LOAD_CNT:  return m_loads;
      CSR_STORE_CNT: return m_stores;
      default:       return '0;
    endcase
  endfunction

  task automatic expect_access(word_t addr, logic we, word_t wdata);
    exp_addr  <= addr;
    exp_we    <= we;
    exp_wdata <= wdata;
    exp_count <= exp_count + 1;
  endtask

  task automatic model_execute(word_t ins);
    reg_addr_t rd;
    word_t     rs1v, rs2v, addr, res;
    logic      wr, halt;
    rd   = ins[11:7];
    rs1v = m_rf[ins[19:15]];
    rs2v = m_rf[ins[24:20]];
    wr   = 1'b1;
    halt = 1'b0;
    res  = '0;
    case (ins[6:0])
      OPC_OP:     res = rs1v + rs2v;
      OPC_OP_IMM: res = rs1v + {{20{ins[31]}}, ins[31:20]};
      OPC_LOAD: begin
        addr = rs1v + {{20{ins[31]}}, ins[31:20]};
        res  = m_mem[addr[7:2]];
        expect_access(addr, 1'b0, '0);
        m_loads++;
      end
      OPC_STORE: begin
        addr = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        m_mem[addr[7:2]] = rs2v;
        expect_access(addr, 1'b1, rs2v);
        m_stores++;
        wr = 1'b0;
      end
      OPC_SYSTEM: begin
        res = csr_value(ins[31:20]);  // old value
        if (ins[31:20] == CSR_MSCRATCH)
          m_mscratch = (ins[14:12] == F3_CSRRW) ? rs1v : (m_mscratch | rs1v);
      end
      default: begin
        wr   = 1'b0;
        halt = 1'b1;
      end
    endcase
    if (wr && rd != '0) m_rf[rd] = res;  // x0 stays zero
    if (halt) begin
      m_halted <= 1'b1;
    end else begin
      m_instret++;
      exp_pc <= exp_pc + WORD_BYTES;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus responders
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (reset_i) begin
      i_pend  = 1'b0;
      i_delay = 0;
    end else if (i_pend) begin
      if (i_delay == 0) begin
        i_word = imem[i_off[7:2]];
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= i_word;
        model_execute(i_word);
        i_pend  = 1'b0;
        i_seed  = lcg_next(i_seed);
        i_delay = latency(i_seed);  // gap before next grant
      end else begin
        i_delay--;
      end
    end else if (instr_req_o && !instr_gnt_i) begin
      if (i_delay == 0) begin
        instr_gnt_i <= 1'b1;
        i_off   = instr_addr_o - BOOT_ADDR;
        i_pend  = 1'b1;
        i_seed  = lcg_next(i_seed);
        i_delay = latency(i_seed);  // rvalid delay
      end else begin
        i_delay--;
      end
    end
  end

  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    if (reset_i) begin
      d_pend  = 1'b0;
      d_delay = 0;
    end else if (d_pend) begin
      if (d_delay == 0) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= d_rdata;
        accesses_done <= accesses_done + 1;
        d_pend  = 1'b0;
        d_seed  = lcg_next(d_seed);
        d_delay = latency(d_seed);
      end else begin
        d_delay--;
      end
    end else if (data_req_o && !data_gnt_i) begin
      if (d_delay == 0) begin
        data_gnt_i <= 1'b1;
        grants     <= grants + 1;
        if (data_we_o) dmem[data_addr_o[7:2]] = data_wdata_o;  // write at grant
        d_rdata = dmem[data_addr_o[7:2]];
        d_pend  = 1'b1;
        d_seed  = lcg_next(d_seed);
        d_delay = latency(d_seed);
      end else begin
        d_delay--;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bus checks against the model
  ////////////////////////////////////////////////////////////
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    !fetch_enable_i |-> !instr_req_o && !data_req_o && !core_busy_o)
    else report_failure("bus request or busy while fetch enable is low");

  a_fetch_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && instr_gnt_i |-> instr_addr_o == exp_pc)
    else report_mismatch("fetch address", $sampled(exp_pc), $sampled(instr_addr_o));

  a_fetch_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else report_failure("fetch request dropped or moved before grant");

  a_halt_no_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
    m_halted |-> !instr_req_o)
    else report_failure("instruction request after the zero word");

  // grants already counts the access that is granted in this cycle
  a_data_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && data_gnt_i |-> exp_count == grants)
    else report_failure("data access that the program does not make");

  a_data_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && data_gnt_i |-> data_addr_o == exp_addr)
    else report_mismatch("data address", $sampled(exp_addr), $sampled(data_addr_o));

  a_data_we: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && data_gnt_i |-> data_we_o == exp_we)
    else report_mismatch("data we", word_t'($sampled(exp_we)), word_t'($sampled(data_we_o)));

  a_data_be: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && data_gnt_i |-> data_be_o == '1)
    else report_mismatch("data be", 32'hF, word_t'($sampled(data_be_o)));

  a_data_wdata: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && data_gnt_i && exp_we |-> data_wdata_o == exp_wdata)
    else report_mismatch("store data", $sampled(exp_wdata), $sampled(data_wdata_o));

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  task automatic load_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i]  = '0;
      dmem[i]  = fill_word(word_t'(i * WORD_BYTES));
      m_mem[i] = dmem[i];
    end
    for (int r = 0; r < NUM_REGS; r++) m_rf[r] = '0;
    m_mscratch = '0;
    m_instret  = '0;
    m_loads    = '0;
    m_stores   = '0;
    imem[0]  = encode_i(OPC_OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd25);
    imem[1]  = encode_i(OPC_OP_IMM, F3_ADD, 5'd2, 5'd0, 12'hFF9);  // -7
    imem[2]  = encode_r(5'd3, 5'd1, 5'd2);
    imem[3]  = encode_i(OPC_OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd5);    // into x0
    imem[4]  = encode_s(5'd3, 5'd0, 12'd0);
    imem[5]  = encode_s(5'd0, 5'd0, 12'd4);
    imem[6]  = encode_i(OPC_LOAD, F3_LW, 5'd5, 5'd0, 12'd64);      // preloaded word
    imem[7]  = encode_r(5'd6, 5'd5, 5'd1);
    imem[8]  = encode_s(5'd6, 5'd0, 12'd8);
    imem[9]  = encode_i(OPC_OP_IMM, F3_ADD, 5'd7, 5'd0, 12'h055);
    imem[10] = encode_i(OPC_SYSTEM, F3_CSRRW, 5'd8, 5'd7, CSR_MSCRATCH);
    imem[11] = encode_i(OPC_SYSTEM, F3_CSRRW, 5'd9, 5'd0, CSR_MSCRATCH);
    imem[12] = encode_s(5'd8, 5'd0, 12'd12);
    imem[13] = encode_s(5'd9, 5'd0, 12'd16);
    imem[14] = encode_i(OPC_SYSTEM, F3_CSRRS, 5'd10, 5'd0, CSR_MINSTRET);
    imem[15] = encode_i(OPC_SYSTEM, F3_CSRRS, 5'd11, 5'd0, CSR_LOAD_CNT);
    imem[16] = encode_i(OPC_SYSTEM, F3_CSRRS, 5'd12, 5'd0, CSR_STORE_CNT);
    imem[17] = encode_s(5'd10, 5'd0, 12'd20);
    imem[18] = encode_s(5'd11, 5'd0, 12'd24);
    imem[19] = encode_s(5'd12, 5'd0, 12'd28);
  endtask

  task automatic start_test(string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != test_start_errors) tests_failed++;
    $display("test %0d %s: %s", tests_run, test_name,
             (errors == test_start_errors) ? "ok" : "errors");
  endtask

  task automatic wait_for_accesses(int n);
    int cycles;
    cycles = 0;
    while (!timed_out && accesses_done < n) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timed_out = 1'b1;
        report_failure($sformatf("timeout waiting for data access %0d", n));
      end
    end
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!timed_out && core_busy_o) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timed_out = 1'b1;
        report_failure("timeout waiting for the core to halt");
      end
    end
  endtask

  initial begin
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset_i        <= 1'b1;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= BOOT_ADDR;
    load_memories();

    start_test("idle after reset");
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (20) @(posedge clk_i);  // enable still low
    finish_test();

    start_test("fetch from boot");
    fetch_enable_i <= 1'b1;
    wait_for_accesses(1);
    finish_test();

    start_test("alu and store");
    wait_for_accesses(2);
    finish_test();

    start_test("load add store");
    wait_for_accesses(4);
    finish_test();

    start_test("csr access");
    wait_for_accesses(9);
    finish_test();

    start_test("halt on zero word");
    wait_for_halt();
    repeat (20) @(posedge clk_i);  // no fetch may follow
    if (!timed_out && !m_halted) report_failure("core stopped before the zero word");
    if (!timed_out && grants != exp_count)
      report_mismatch("data accesses", word_t'(exp_count), word_t'(grants));
    finish_test();

    $display("%0d tests, %0d with errors, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tb.f
logic/riscv_core_pkg.sv
logic/riscv_isa_pkg.sv
logic/riscv_lsu_if.sv
logic/riscv_controller.sv
logic/riscv_fetch_unit.sv
logic/riscv_ex_stage.sv
logic/riscv_load_store_unit.sv
logic/riscv_cs_registers.sv
logic/riscv_core.sv
sim/tb_riscv_core.sv
